// ==== Bender.yml ====
package:
  name: fetch_top

dependencies: {}

sources:
  # Shared package first
  - common/fetch_pkg.sv
  # Leaf blocks
  - source/instr_mem.sv
  - source/imem_arbiter.sv
  - fetch/fetch_unit.sv
  - loader/prog_loader.sv
  # Top level
  - source/fetch_top.sv
  # Testbench
  - target: test
    files:
      - tb/fetch_top_tb.sv

// ==== common/fetch_pkg.sv ====
package fetch_pkg;

   // Instruction word width in bits
   localparam int DATA_W = 32;

   // Word address of the instruction RAM
   localparam int ADDR_W = 10;

   // Number of words in the instruction RAM
   localparam int MEM_DEPTH = 1 << ADDR_W;

   // Program counter width
   // The PC is a byte address, so word address = PC[ADDR_W+1:2]
   localparam int PC_W = 32;

   // sll $0,$0,0 encodes as all zeros
   // Goes into the fetch output register in place of a squashed word
   localparam logic [DATA_W-1:0] NOP_INSTR = '0;

   // Program loader FSM
   typedef enum logic [1:0] {
      LD_IDLE,    // Waiting for the first start pulse
      LD_COLLECT, // Shifting in bytes of the current word
      LD_WRITE    // Word complete, one write request to the RAM
   } loader_state_t;

   // Holder of the single RAM port in a given cycle
   typedef enum logic {
      OWN_FETCH,  // Fetch unit reads
      OWN_LOADER  // Loader writes, fetch waits
   } mem_owner_t;

endpackage

// ==== fetch/fetch_unit.sv ====
`timescale 1ns/1ps

// Program counter and next-PC selection for the IF stage
// The PC is a byte address, the RAM sees bits ADDR_W+1:2 of it
module fetch_unit (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_grant,         // RAM port is ours this cycle
   input  logic                         i_stall,         // Hold the PC, level
   input  logic                         i_branch_taken,  // One-cycle strobe from decode
   input  logic [fetch_pkg::PC_W-1:0]   i_branch_target, // Byte address
   output logic [fetch_pkg::ADDR_W-1:0] o_fetch_addr,    // Word address to the arbiter
   output logic                         o_flush,         // Squash the word read this cycle
   output logic                         o_if_id_we,      // IF/ID register enable
   output logic [fetch_pkg::PC_W-1:0]   o_pc_plus4       // Aligned with the RAM output
);

   logic [fetch_pkg::PC_W-1:0] pc_q;
   logic [fetch_pkg::PC_W-1:0] pc_next;
   logic [fetch_pkg::PC_W-1:0] pc_plus4;
   logic [fetch_pkg::PC_W-1:0] pc_plus4_q;
   logic                       branch_ok;  // Branch seen while we own the port

   assign pc_plus4  = pc_q + fetch_pkg::PC_W'(4);
   assign branch_ok = i_branch_taken & i_grant;

   // Next PC
   // Branch beats stall, no grant means the cycle belongs to the loader
   always_comb begin
      if (branch_ok) begin
         pc_next = i_branch_target;
      end else if (i_grant && !i_stall) begin
         pc_next = pc_plus4;
      end else begin
         pc_next = pc_q;  // Same word gets read again
      end
   end

   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_q <= '0;
      end else begin
         pc_q <= pc_next;
      end
   end

   // PC+4 of the word being read, registered in step with the RAM read register
   // so decode sees the pair together
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         pc_plus4_q <= '0;
      end else begin
         pc_plus4_q <= pc_plus4;
      end
   end

   // Word address, low two bits are the byte offset
   assign o_fetch_addr = pc_q[fetch_pkg::ADDR_W+1:2];

   // Wrong-path word read this cycle comes out as NOP
   assign o_flush = branch_ok;

   // IF/ID advances only when fetch runs and decode is not stalled
   assign o_if_id_we = i_grant & ~i_stall;

   assign o_pc_plus4 = pc_plus4_q;

endmodule

// ==== filelist.f ====
common/fetch_pkg.sv
source/instr_mem.sv
source/imem_arbiter.sv
fetch/fetch_unit.sv
loader/prog_loader.sv
source/fetch_top.sv
tb/fetch_top_tb.sv

// ==== loader/prog_loader.sv ====
`timescale 1ns/1ps

// Debug-link program loader
// Packs four bytes into one little-endian word and writes it at the next address
module prog_loader (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic                         i_load_start,   // Restart at word 0
   input  logic [7:0]                   i_byte,         // Byte from the debug link
   input  logic                         i_byte_valid,   // Byte strobe
   output logic                         o_wr_req,       // One-cycle write request
   output logic [fetch_pkg::ADDR_W-1:0] o_wr_addr,      // Word address of the write
   output logic [fetch_pkg::DATA_W-1:0] o_wr_data,      // Assembled word
   output logic [fetch_pkg::ADDR_W:0]   o_words_loaded  // Words written since reset
);

   fetch_pkg::loader_state_t state_q;
   fetch_pkg::loader_state_t state_d;

   logic [1:0]                   byte_cnt_q;  // Bytes of the current word so far
   logic [fetch_pkg::ADDR_W-1:0] ptr_q;       // Next write address
   logic [fetch_pkg::ADDR_W:0]   words_q;
   logic [fetch_pkg::DATA_W-1:0] word_q;      // Shift register, first byte ends up in [7:0]
   logic                         take_byte;

   // Bytes only count while collecting, a byte during LD_WRITE is lost
   assign take_byte = i_byte_valid && (state_q == fetch_pkg::LD_COLLECT);

   // Next state
   always_comb begin
      state_d = state_q;
      if (i_load_start) begin
         state_d = fetch_pkg::LD_COLLECT;
      end else begin
         case (state_q)
            fetch_pkg::LD_IDLE:    state_d = fetch_pkg::LD_IDLE;
            fetch_pkg::LD_COLLECT: begin
               if (take_byte && byte_cnt_q == 2'd3) begin
                  state_d = fetch_pkg::LD_WRITE;  // Fourth byte completes the word
               end
            end
            fetch_pkg::LD_WRITE:   state_d = fetch_pkg::LD_COLLECT;
            default:               state_d = fetch_pkg::LD_IDLE;
         endcase
      end
   end

   // Control state
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         state_q    <= fetch_pkg::LD_IDLE;
         byte_cnt_q <= '0;
         ptr_q      <= '0;
         words_q    <= '0;
      end else begin
         state_q <= state_d;
         if (i_load_start) begin
            byte_cnt_q <= '0;
            ptr_q      <= '0;
         end else begin
            if (take_byte) begin
               byte_cnt_q <= byte_cnt_q + 2'd1;  // Wraps to 0 after the fourth byte
            end
            if (state_q == fetch_pkg::LD_WRITE) begin
               ptr_q   <= ptr_q + 1'b1;   // Write lands at the old pointer this edge
               words_q <= words_q + 1'b1;
            end
         end
      end
   end

   // Little-endian assembly, new bytes enter at the top and move down
   always_ff @(posedge i_clk) begin
      if (take_byte) begin
         word_q <= {i_byte, word_q[fetch_pkg::DATA_W-1:8]};
      end
   end

   assign o_wr_req       = (state_q == fetch_pkg::LD_WRITE);
   assign o_wr_addr      = ptr_q;
   assign o_wr_data      = word_q;
   assign o_words_loaded = words_q;

endmodule

// ==== source/fetch_top.sv ====
`timescale 1ns/1ps

// Instruction-fetch subsystem
// Fetch unit and program loader share one RAM port through the arbiter
module fetch_top (
   input  logic                         i_clk,
   input  logic                         i_rst,
   // Pipeline control
   input  logic                         i_stall,
   input  logic                         i_branch_taken,
   input  logic [fetch_pkg::PC_W-1:0]   i_branch_target,
   // Debug link
   input  logic                         i_load_start,
   input  logic [7:0]                   i_byte,
   input  logic                         i_byte_valid,
   // To decode
   output logic [fetch_pkg::DATA_W-1:0] o_instr,
   output logic [fetch_pkg::PC_W-1:0]   o_pc_plus4,
   output logic                         o_instr_valid,
   // Loader status
   output logic [fetch_pkg::ADDR_W:0]   o_words_loaded
);

   // Fetch side
   logic [fetch_pkg::ADDR_W-1:0] fetch_addr;
   logic                         fetch_grant;
   logic                         flush;
   logic                         if_id_we;

   // Loader side
   logic                         ld_req;
   logic [fetch_pkg::ADDR_W-1:0] ld_addr;
   logic [fetch_pkg::DATA_W-1:0] ld_data;

   // Arbitrated RAM port
   logic [fetch_pkg::ADDR_W-1:0] mem_addr;
   logic [fetch_pkg::DATA_W-1:0] mem_data;
   logic                         mem_we;

   fetch_unit u_fetch_unit (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_grant         (fetch_grant),
      .i_stall         (i_stall),
      .i_branch_taken  (i_branch_taken),
      .i_branch_target (i_branch_target),
      .o_fetch_addr    (fetch_addr),
      .o_flush         (flush),
      .o_if_id_we      (if_id_we),
      .o_pc_plus4      (o_pc_plus4)
   );

   prog_loader u_prog_loader (
      .i_clk          (i_clk),
      .i_rst          (i_rst),
      .i_load_start   (i_load_start),
      .i_byte         (i_byte),
      .i_byte_valid   (i_byte_valid),
      .o_wr_req       (ld_req),
      .o_wr_addr      (ld_addr),
      .o_wr_data      (ld_data),
      .o_words_loaded (o_words_loaded)
   );

   imem_arbiter u_imem_arbiter (
      .i_clk         (i_clk),
      .i_rst         (i_rst),
      .i_fetch_addr  (fetch_addr),
      .i_ld_req      (ld_req),
      .i_ld_addr     (ld_addr),
      .i_ld_data     (ld_data),
      .o_mem_addr    (mem_addr),
      .o_mem_data    (mem_data),
      .o_mem_we      (mem_we),
      .o_fetch_grant (fetch_grant),
      .o_instr_valid (o_instr_valid)
   );

   // Flush and IF/ID enable go straight from fetch to the RAM
   instr_mem u_instr_mem (
      .i_clk      (i_clk),
      .i_rst      (i_rst),
      .i_addr     (mem_addr),
      .i_data     (mem_data),
      .i_wea      (mem_we),
      .i_flush    (flush),
      .i_if_id_we (if_id_we),
      .o_data     (o_instr)
   );

endmodule

// ==== source/imem_arbiter.sv ====
`timescale 1ns/1ps

// Shares the RAM port between the fetch unit and the program loader
// The loader always wins, fetch simply loses that cycle
module imem_arbiter (
   input  logic                         i_clk,
   input  logic                         i_rst,
   input  logic [fetch_pkg::ADDR_W-1:0] i_fetch_addr,  // Read address from fetch
   input  logic                         i_ld_req,      // Loader write strobe
   input  logic [fetch_pkg::ADDR_W-1:0] i_ld_addr,     // Loader write address
   input  logic [fetch_pkg::DATA_W-1:0] i_ld_data,     // Loader write data
   output logic [fetch_pkg::ADDR_W-1:0] o_mem_addr,
   output logic [fetch_pkg::DATA_W-1:0] o_mem_data,
   output logic                         o_mem_we,
   output logic                         o_fetch_grant, // Fetch owns the port this cycle
   output logic                         o_instr_valid  // RAM output holds a fetched word
);

   fetch_pkg::mem_owner_t owner;    // Owner in the current cycle
   fetch_pkg::mem_owner_t owner_q;  // Owner of the word now in the RAM output register

   // Fixed priority, loader first
   always_comb begin
      if (i_ld_req) begin
         owner = fetch_pkg::OWN_LOADER;
      end else begin
         owner = fetch_pkg::OWN_FETCH;
      end
   end

   // Port mux
   assign o_mem_addr    = (owner == fetch_pkg::OWN_LOADER) ? i_ld_addr : i_fetch_addr;
   assign o_mem_data    = i_ld_data;                          // Only the loader writes
   assign o_mem_we      = (owner == fetch_pkg::OWN_LOADER);
   assign o_fetch_grant = (owner == fetch_pkg::OWN_FETCH);

   // Track who filled the RAM output register
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         owner_q <= fetch_pkg::OWN_LOADER;  // Output after reset is not a fetched word
      end else begin
         owner_q <= owner;
      end
   end

   // A write cycle leaves the written data on the RAM output, so no valid then
   assign o_instr_valid = (owner_q == fetch_pkg::OWN_FETCH);

endmodule

// ==== source/instr_mem.sv ====
`timescale 1ns/1ps

// Single-port block RAM, write-first, one cycle read latency
// No output pipeline register, o_data comes straight from the read register
module instr_mem (
   input  logic                         i_clk,
   input  logic                         i_rst,      // Clears the output word only
   input  logic [fetch_pkg::ADDR_W-1:0] i_addr,     // Word address
   input  logic [fetch_pkg::DATA_W-1:0] i_data,     // Write data from the loader
   input  logic                         i_wea,      // Write enable
   input  logic                         i_flush,    // Squash the word read this cycle
   input  logic                         i_if_id_we, // IF/ID register enable
   output logic [fetch_pkg::DATA_W-1:0] o_data      // Registered instruction word
);

   // Storage array, contents survive reset
   logic [fetch_pkg::DATA_W-1:0] mem [0:fetch_pkg::MEM_DEPTH-1];

   // Read register feeding the decode stage
   logic [fetch_pkg::DATA_W-1:0] data_q;

   // Array write port
   always_ff @(posedge i_clk) begin
      if (i_wea) begin
         mem[i_addr] <= i_data;
      end
   end

   // Output word
   // Write-first: a written word shows up on the output after the same edge
   always_ff @(posedge i_clk) begin
      if (i_rst) begin
         data_q <= '0;
      end else if (i_wea) begin
         data_q <= i_data;                            // Write-through
      end else begin
         case ({i_flush, i_if_id_we})
            2'b01:   data_q <= mem[i_addr];           // Normal fetch
            2'b10,
            2'b11:   data_q <= fetch_pkg::NOP_INSTR;  // Branch squash
            default: data_q <= mem[i_addr];           // Stalled, same PC is read again
         endcase
      end
   end

   assign o_data = data_q;

endmodule

// ==== tb/fetch_top_tb.sv ====
`timescale 1ns/1ps

// Self-checking testbench for the instruction-fetch subsystem
// Loads a random program over the byte link and then steps fetch through a table
module fetch_top_tb;

   localparam int PROG_WORDS     = 32;    // First program
   localparam int RELOAD_WORDS   = 8;     // Second load that rewrites from word 0
   localparam int N_ROWS         = 33;    // Fetch table length
   localparam int TIMEOUT_CYCLES = 2000;  // Limit for every wait loop

   logic                         i_clk;
   logic                         i_rst;
   logic                         i_stall;
   logic                         i_branch_taken;
   logic [fetch_pkg::PC_W-1:0]   i_branch_target;
   logic                         i_load_start;
   logic [7:0]                   i_byte;
   logic                         i_byte_valid;
   logic [fetch_pkg::DATA_W-1:0] o_instr;
   logic [fetch_pkg::PC_W-1:0]   o_pc_plus4;
   logic                         o_instr_valid;
   logic [fetch_pkg::ADDR_W:0]   o_words_loaded;

   // Memory model and the words sent over the byte link
   logic [fetch_pkg::DATA_W-1:0] model_mem [0:PROG_WORDS-1];
   logic [fetch_pkg::DATA_W-1:0] load_buf  [0:PROG_WORDS-1];

   // Fetch table with one row per cycle
   logic                         row_stall  [0:N_ROWS-1];
   logic                         row_branch [0:N_ROWS-1];
   logic [fetch_pkg::PC_W-1:0]   row_target [0:N_ROWS-1];
   logic [fetch_pkg::PC_W-1:0]   row_pc4    [0:N_ROWS-1];  // Expected o_pc_plus4 where 0 means unchecked

   logic [fetch_pkg::PC_W-1:0]   pc_model;  // PC during the row being applied

   int          error_count;
   int          check_count;
   int unsigned seed;
   int unsigned rnd;

   fetch_top DUT (
      .i_clk           (i_clk),
      .i_rst           (i_rst),
      .i_stall         (i_stall),
      .i_branch_taken  (i_branch_taken),
      .i_branch_target (i_branch_target),
      .i_load_start    (i_load_start),
      .i_byte          (i_byte),
      .i_byte_valid    (i_byte_valid),
      .o_instr         (o_instr),
      .o_pc_plus4      (o_pc_plus4),
      .o_instr_valid   (o_instr_valid),
      .o_words_loaded  (o_words_loaded)
   );

   initial begin
      i_clk = 1'b0;
      forever #50 i_clk = ~i_clk;  // 100 ns period
   end

   task check_eq(input string name, input logic [31:0] expected, input logic [31:0] actual);
      check_count++;
      if (actual !== expected) begin
         error_count++;
         $display("** Error at %0t: %s expected %h, got %h", $time, name, expected, actual);
      end
   endtask

   task set_row(input int idx, input logic s, input logic b, input int tgt, input int pc4);
      row_stall[idx]  = s;
      row_branch[idx] = b;
      row_target[idx] = tgt;
      row_pc4[idx]    = pc4;
   endtask

   // Arguments are index, stall, branch, target and expected PC+4
   task build_table();
      set_row(0,  0, 0, 0,   4);
      set_row(1,  0, 0, 0,   8);
      set_row(2,  0, 0, 0,   12);
      set_row(3,  1, 0, 0,   16);   // Stall holds PC at 12
      set_row(4,  1, 0, 0,   16);
      set_row(5,  1, 0, 0,   16);
      set_row(6,  0, 0, 0,   16);   // Word 3 once more and then advance
      set_row(7,  0, 1, 40,  20);   // Branch squashes the wrong-path word
      set_row(8,  0, 0, 0,   44);
      set_row(9,  0, 0, 0,   48);
      set_row(10, 1, 1, 100, 52);   // Branch wins over stall
      set_row(11, 1, 0, 0,   104);
      set_row(12, 0, 0, 0,   104);
      set_row(13, 0, 1, 8,   108);
      set_row(14, 0, 1, 64,  12);   // Back-to-back branches
      set_row(15, 0, 0, 0,   68);
      set_row(16, 0, 0, 0,   72);
      set_row(17, 1, 0, 0,   76);
      set_row(18, 0, 0, 0,   76);
      set_row(19, 0, 1, 0,   80);   // Back to the start
      set_row(20, 0, 0, 0,   4);
      set_row(21, 0, 0, 0,   8);
      set_row(22, 0, 1, 0,   0);    // PC is not tracked after the reload
      for (int r = 23; r < N_ROWS; r++) begin
         set_row(r, 0, 0, 0, 4 * (r - 22));  // Straight run over new and old words
      end
   endtask

   task drive_row(input int idx);
      i_stall         <= row_stall[idx];
      i_branch_taken  <= row_branch[idx];
      i_branch_target <= row_target[idx];
   endtask

   // Start pulse followed by four bytes per word with the first byte as bits 7:0
   task send_words(input int count);
      @(posedge i_clk);
      i_load_start <= 1'b1;
      @(posedge i_clk);
      i_load_start <= 1'b0;
      for (int w = 0; w < count; w++) begin
         for (int b = 0; b < 4; b++) begin
            @(posedge i_clk);
            i_byte       <= load_buf[w][8*b +: 8];
            i_byte_valid <= 1'b1;
            @(posedge i_clk);
            i_byte_valid <= 1'b0;  // Strobes two cycles apart
         end
      end
   endtask

   task wait_words(input int target);
      int cycles;
      cycles = 0;
      while (o_words_loaded != target && cycles < TIMEOUT_CYCLES) begin
         @(negedge i_clk);
         cycles++;
      end
      if (o_words_loaded != target) begin
         error_count++;
         $display("Timeout: loader reports %0d words, waiting for %0d", o_words_loaded, target);
      end
   endtask

   task wait_valid();
      int cycles;
      cycles = 0;
      @(negedge i_clk);
      while (!o_instr_valid && cycles < TIMEOUT_CYCLES) begin
         @(negedge i_clk);
         cycles++;
      end
      if (!o_instr_valid) begin
         error_count++;
         $display("Timeout: no valid instruction came out of fetch");
      end
   endtask

   // Watches the RAM output while the loader rewrites words with fetch running
   task watch_reload(input int count);
      int                         writes;
      int                         cycles;
      logic [fetch_pkg::ADDR_W:0] last_words;
      writes     = 0;
      cycles     = 0;
      last_words = o_words_loaded;
      while (writes < count && cycles < TIMEOUT_CYCLES) begin
         @(negedge i_clk);
         cycles++;
         if (o_words_loaded != last_words) begin
            // Written word shows on the output in a write cycle
            check_eq("o_instr_valid", 0, o_instr_valid);
            check_eq("o_instr", load_buf[writes], o_instr);
            last_words = o_words_loaded;
            writes++;
         end else begin
            check_eq("o_instr_valid", 1, o_instr_valid);  // Fetch owns the port
         end
      end
      if (writes < count) begin
         error_count++;
         $display("Timeout: saw %0d of %0d loader writes during fetch", writes, count);
      end
   endtask

   // Applies rows first..last back to back and checks each one after its edge
   task run_rows(input int first, input int last);
      logic [fetch_pkg::DATA_W-1:0] exp_instr;
      @(posedge i_clk);
      drive_row(first);
      for (int i = first; i <= last; i++) begin
         @(posedge i_clk);        // Row i is registered here
         if (i < last) begin
            drive_row(i + 1);
         end else begin
            i_stall        <= 1'b1;  // Park fetch after the last row
            i_branch_taken <= 1'b0;
         end
         @(negedge i_clk);
         if (row_branch[i]) begin
            exp_instr = 32'h0000_0000;  // sll $0,$0,0 replaces the wrong-path word
         end else begin
            exp_instr = model_mem[pc_model[6:2]];  // Program sits in the first 32 words
         end
         check_eq("o_instr_valid", 1, o_instr_valid);
         check_eq("o_instr", exp_instr, o_instr);
         if (row_pc4[i] != 0) begin
            check_eq("o_pc_plus4", row_pc4[i], o_pc_plus4);
         end
         // Next PC where branch beats stall
         if (row_branch[i]) begin
            pc_model = row_target[i];
         end else if (!row_stall[i]) begin
            pc_model = pc_model + 4;
         end
      end
   endtask

   initial begin
      i_rst           = 1'b1;
      i_stall         = 1'b1;  // PC parked at 0 until the program is in
      i_branch_taken  = 1'b0;
      i_branch_target = '0;
      i_load_start    = 1'b0;
      i_byte          = '0;
      i_byte_valid    = 1'b0;
      error_count     = 0;
      check_count     = 0;
      pc_model        = '0;
      seed            = 32'hbb7a1437;
      rnd             = $urandom(seed);
      for (int w = 0; w < PROG_WORDS; w++) begin
         load_buf[w] = $urandom();
      end
      build_table();

      repeat (2) @(posedge i_clk);
      i_rst <= 1'b0;

      // Reset state
      @(negedge i_clk);
      check_eq("o_instr_valid", 0, o_instr_valid);
      check_eq("o_words_loaded", 0, o_words_loaded);
      wait_valid();
      check_eq("o_pc_plus4", 4, o_pc_plus4);

      // First program with fetch stalled on word 0
      send_words(PROG_WORDS);
      wait_words(PROG_WORDS);
      for (int w = 0; w < PROG_WORDS; w++) begin
         model_mem[w] = load_buf[w];
      end
      wait_valid();
      check_eq("o_instr", model_mem[0], o_instr);
      check_eq("o_pc_plus4", 4, o_pc_plus4);

      // Sequential fetch, stalls and branches
      pc_model = '0;
      run_rows(0, 21);

      // Second load while fetch runs
      for (int w = 0; w < RELOAD_WORDS; w++) begin
         load_buf[w] = $urandom();
      end
      @(posedge i_clk);
      i_stall <= 1'b0;
      fork
         send_words(RELOAD_WORDS);
         watch_reload(RELOAD_WORDS);
      join
      wait_words(PROG_WORDS + RELOAD_WORDS);  // Count is not cleared by a start pulse
      for (int w = 0; w < RELOAD_WORDS; w++) begin
         model_mem[w] = load_buf[w];
      end

      // Branch to 0 and read back new and old words
      run_rows(22, N_ROWS - 1);

      $display("Fetch test done: %0d checks, %0d errors", check_count, error_count);
      if (error_count == 0) begin
         $display("sim passed");
      end else begin
         $display("sim failed");
      end
      $finish;
   end

endmodule
